// ==== Makefile ====
# Verilator flow for the 16-point FFT: lint, sim and clean.

VERILATOR ?= verilator
TOP       ?= fft_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation incomplete, see $(LOG)"; exit 1; fi
	@echo "Simulation finished without failures"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
+incdir+.
rtl/fft_pkg.sv
rtl/fft_input_buffer.sv
rtl/fft_stage_counter.sv
rtl/fft_ctrl.sv
rtl/fft_butterfly.sv
rtl/fft_work_ram.sv
rtl/fft_output_buffer.sv
rtl/fft_dit_top.sv
dv/tb_clock_gen.sv
dv/fft_tb.sv

// ==== dv/fft_tb.sv ====
// Testbench for the 16-point DIT FFT top level.
// Sends frames on in_nd and checks every out_nd burst against a bit-exact model.
`timescale 1ns/1ps
`default_nettype none
`include "fft_cfg.svh"

module fft_tb;

   typedef fft_pkg::sample_t [`FFT_N-1:0] frame_t;

   localparam logic [31:0] SEED          = 32'h3d76309d;
   localparam int          RANDOM_FRAMES = 10;
   localparam int          STREAM_FRAMES = 6;
   localparam int          WAIT_LIMIT    = 500;

   logic             clk;
   logic             por_n;
   logic             soft_rst_n;
   logic             rst_n;
   fft_pkg::sample_t in_x;
   logic             in_nd;
   fft_pkg::sample_t out_x;
   logic             out_nd;
   logic             overflow;

   logic [31:0] lfsr_state;
   int          error_count = 0;
   int          check_count = 0;
   int          frames_sent = 0;
   int          frames_seen = 0;
   frame_t      exp_q [$];

   // Power-on reset from the clock module and a reset the tests can pulse.
   assign rst_n = por_n && soft_rst_n;

   tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(3)) u_clk (.clk, .rst_n (por_n));

   fft_dit_top UUT (.clk, .rst_n, .in_x, .in_nd, .out_x, .out_nd, .overflow);

   // Galois LFSR with taps 32, 31, 29 and 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
   endfunction

   // One LFSR step per bit taken with the first bit ending up on top.
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         v          = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   function automatic frame_t random_frame();
      frame_t      f;
      logic [31:0] v;
      int          i;
      for (i = 0; i < `FFT_N; i++)
      begin
         v       = random_bits(`FFT_X_WIDTH);
         f[i].re = v[`FFT_X_WIDTH-1:0];
         v       = random_bits(`FFT_X_WIDTH);
         f[i].im = v[`FFT_X_WIDTH-1:0];
      end
      return f;
   endfunction

   // Model of the whole transform.
   // Each stage halves S and writes its butterflies to o and o + N/2.
   function automatic frame_t fft_ref(input frame_t x);
      frame_t cur;
      frame_t nxt;
      int     st, s, mask, o, i0, i1, k;
      int     a_re, a_im, b_re, b_im, w_re, w_im, p_re, p_im, t;
      cur = x;
      for (st = 0; st < `FFT_NLOG2; st++)
      begin
         s    = (`FFT_N / 2) >> st;
         mask = s - 1;
         for (o = 0; o < `FFT_N / 2; o++)
         begin
            i0   = (o & mask) | ((o & ~mask) << 1);
            i1   = i0 + s;
            k    = o & ~mask;
            a_re = int'(cur[i0].re);
            a_im = int'(cur[i0].im);
            b_re = int'(cur[i1].re);
            b_im = int'(cur[i1].im);
            w_re = int'(fft_pkg::TWIDDLE[k].re);
            w_im = int'(fft_pkg::TWIDDLE[k].im);
            // Twiddle product with the fraction bits dropped.
            p_re = (w_re * b_re - w_im * b_im) >>> `FFT_TF_FRAC;
            p_im = (w_re * b_im + w_im * b_re) >>> `FFT_TF_FRAC;
            // Sum and difference are halved and cut to sample width.
            t                       = (a_re + p_re) >>> 1;
            nxt[o].re               = t[`FFT_X_WIDTH-1:0];
            t                       = (a_im + p_im) >>> 1;
            nxt[o].im               = t[`FFT_X_WIDTH-1:0];
            t                       = (a_re - p_re) >>> 1;
            nxt[o + `FFT_N / 2].re  = t[`FFT_X_WIDTH-1:0];
            t                       = (a_im - p_im) >>> 1;
            nxt[o + `FFT_N / 2].im  = t[`FFT_X_WIDTH-1:0];
         end
         cur = nxt;
      end
      return cur;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count++;
      if (got !== exp)
      begin
         error_count++;
         $display("error: %s got %0h expected %0h", name, got, exp);
      end
   endtask

   task automatic end_run();
      $display("summary: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   endtask

   task automatic drive_sample(input fft_pkg::sample_t s);
      @(negedge clk);
      in_x  = s;
      in_nd = 1'b1;
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(negedge clk);
         in_nd = 1'b0;
      end
   endtask

   // Sends a full frame with gap idle cycles after each sample.
   task automatic send_frame(input frame_t f, input int gap);
      int i;
      for (i = 0; i < `FFT_N; i++)
      begin
         drive_sample(f[i]);
         idle(gap);
      end
      idle(1);
      exp_q.push_back(fft_ref(f));
      frames_sent++;
   endtask

   // Frame counters move on the falling edge and are polled on the rising one.
   task automatic wait_for_frames(input string what);
      int cycles;
      cycles = 0;
      while (frames_seen < frames_sent && cycles < WAIT_LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      if (frames_seen < frames_sent)
      begin
         $display("timeout in %s: only %0d of %0d frames came out",
                  what, frames_seen, frames_sent);
         error_count++;
         end_run();
      end
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (rst_n !== 1'b1 && cycles < WAIT_LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      if (rst_n !== 1'b1)
      begin
         $display("timeout: reset was never released");
         error_count++;
         end_run();
      end
   endtask

   // Outputs must stay quiet for n cycles.
   task automatic quiet_check(input int n);
      repeat (n)
      begin
         @(negedge clk);
         check_value("out_nd", 32'(out_nd), 32'd0);
         check_value("overflow", 32'(overflow), 32'd0);
      end
   endtask

   task automatic pulse_reset();
      @(negedge clk);
      in_nd      = 1'b0;
      soft_rst_n = 1'b0;
      repeat (3) @(negedge clk);
      soft_rst_n = 1'b1;
   endtask

   // Collects each out_nd burst and compares it with the oldest expected frame.
   initial
   begin : compare_outputs
      frame_t got;
      frame_t exp;
      int     bin;
      logic   burst_ok;
      forever
      begin
         @(negedge clk);
         if (out_nd === 1'b1)
         begin
            got[0]   = out_x;
            burst_ok = 1'b1;
            for (bin = 1; bin < `FFT_N; bin++)
            begin
               @(negedge clk);
               if (out_nd !== 1'b1 && burst_ok)
               begin
                  $display("out_nd dropped after %0d cycles of a burst", bin);
                  error_count++;
                  burst_ok = 1'b0;
               end
               got[bin] = out_x;
            end
            // A burst is exactly one frame long.
            @(negedge clk);
            if (out_nd === 1'b1)
            begin
               $display("out_nd stayed high past %0d cycles", `FFT_N);
               error_count++;
            end
            if (exp_q.size() == 0)
            begin
               $display("an output frame came out with no frame sent");
               error_count++;
            end
            else
            begin
               exp = exp_q.pop_front();
               for (bin = 0; bin < `FFT_N; bin++)
                  check_value($sformatf("out_x bin %0d of frame %0d", bin, frames_seen),
                              32'(got[bin]), 32'(exp[bin]));
            end
            frames_seen++;
         end
      end
   end

   initial
   begin : run_tests
      frame_t f;
      frame_t spare;
      int     n;
      in_x       = '0;
      in_nd      = 1'b0;
      soft_rst_n = 1'b1;
      lfsr_state = SEED;
      wait_reset_release();

      // Quiet after reset with no input.
      quiet_check(50);

      // Impulse frame.
      f       = '0;
      f[0].re = 12'sd800;
      f[0].im = -12'sd300;
      send_frame(f, 0);
      wait_for_frames("impulse frame");

      // Random frames whose output finishes before the next frame starts.
      for (n = 0; n < RANDOM_FRAMES; n++)
      begin
         send_frame(random_frame(), 0);
         wait_for_frames("random frames");
         idle(8);
      end
      check_value("overflow", 32'(overflow), 32'd0);

      // Frame period of 49 cycles is above the 45 the FSM needs per frame.
      for (n = 0; n < STREAM_FRAMES; n++)
      begin
         send_frame(random_frame(), 1);
         idle(16);
      end
      wait_for_frames("streamed frames");
      check_value("overflow", 32'(overflow), 32'd0);

      // 32 samples in a row where most of the second half hits a full buffer.
      f     = random_frame();
      spare = random_frame();
      for (n = 0; n < `FFT_N; n++)
         drive_sample(f[n]);
      for (n = 0; n < `FFT_N; n++)
         drive_sample(spare[n]);
      idle(1);
      exp_q.push_back(fft_ref(f));
      frames_sent++;
      check_value("overflow", 32'(overflow), 32'd1);
      wait_for_frames("overflow frame");
      idle(100);
      check_value("overflow", 32'(overflow), 32'd1);
      check_value("frames_seen", 32'(frames_seen), 32'(frames_sent));

      // Reset in the middle of a frame.
      f = random_frame();
      for (n = 0; n < 7; n++)
         drive_sample(f[n]);
      pulse_reset();
      @(negedge clk);
      check_value("overflow", 32'(overflow), 32'd0);
      check_value("out_nd", 32'(out_nd), 32'd0);
      send_frame(random_frame(), 0);
      wait_for_frames("frame after reset");
      check_value("overflow", 32'(overflow), 32'd0);

      end_run();
   end

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
// Clock and power-on reset source for the FFT testbench.
// The period and the reset length are set by parameters.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 3
) (
   output logic clk,
   output logic rst_n
);

   // Free running clock, low in the first half period.
   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Reset spans RESET_CYCLES rising edges and lets go on a falling edge.
   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== fft_cfg.svh ====
// Size, width and timing constants for the 16-point DIT FFT.
// Included by every RTL file before the package is referenced.
`ifndef FFT_CFG_SVH
`define FFT_CFG_SVH

// Frame length and its base two log.
`define FFT_N 16
`define FFT_NLOG2 4

// Bits in each real or imaginary part.
`define FFT_X_WIDTH 12

// Twiddle fraction bits, so 1.0 is 1024.
`define FFT_TF_FRAC 10

// Cycles from issue to y_valid in the butterfly.
`define FFT_BF_LATENCY 3

`endif

// ==== rtl/fft_butterfly.sv ====
// Pipelined radix-2 butterfly with twiddle multiply and halving.
// Write tags ride along with the data and come out FFT_BF_LATENCY cycles later.
`timescale 1ns/1ps
`default_nettype none
`include "fft_cfg.svh"

module fft_butterfly (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             issue,
   input  fft_pkg::sample_t a,
   input  fft_pkg::sample_t b,
   input  fft_pkg::sample_t w,
   input  fft_pkg::addr_t   tag_out0,
   input  fft_pkg::addr_t   tag_out1,
   input  logic             tag_last,
   input  logic             tag_bank,
   output logic             y_valid,
   output fft_pkg::sample_t y0,
   output fft_pkg::sample_t y1,
   output fft_pkg::addr_t   y_out0,
   output fft_pkg::addr_t   y_out1,
   output logic             y_last,
   output logic             y_bank
);

   localparam int PW = 2 * `FFT_X_WIDTH + 1;
   localparam int SW = PW + 1;
   localparam int TW = 2 * `FFT_NLOG2 + 2;

   logic                 v1, v2;
   logic [TW-1:0]        tag1, tag2;
   fft_pkg::sample_t     a1, b1, w1, a2;
   logic signed [PW-1:0] prod_re, prod_im, p2_re, p2_im;
   logic signed [SW-1:0] sum_re, sum_im, dif_re, dif_im;

   // Valid is the only control bit in the pipe.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         v1      <= 1'b0;
         v2      <= 1'b0;
         y_valid <= 1'b0;
      end
      else
      begin
         v1      <= issue;
         v2      <= v1;
         y_valid <= v2;
      end
   end

   // Twiddle times b at full width.
   always_comb
   begin
      prod_re = PW'(w1.re) * PW'(b1.re) - PW'(w1.im) * PW'(b1.im);
      prod_im = PW'(w1.re) * PW'(b1.im) + PW'(w1.im) * PW'(b1.re);
      sum_re  = SW'(a2.re) + SW'(p2_re);
      sum_im  = SW'(a2.im) + SW'(p2_im);
      dif_re  = SW'(a2.re) - SW'(p2_re);
      dif_im  = SW'(a2.im) - SW'(p2_im);
   end

   always_ff @(posedge clk)
   begin
      // Stage 1 registers the operands and tags.
      a1   <= a;
      b1   <= b;
      w1   <= w;
      tag1 <= {tag_out0, tag_out1, tag_last, tag_bank};
      // Stage 2 drops the twiddle fraction bits.
      a2    <= a1;
      p2_re <= prod_re >>> `FFT_TF_FRAC;
      p2_im <= prod_im >>> `FFT_TF_FRAC;
      tag2  <= tag1;
      // Stage 3 halves and truncates both results.
      y0.re <= sum_re[`FFT_X_WIDTH:1];
      y0.im <= sum_im[`FFT_X_WIDTH:1];
      y1.re <= dif_re[`FFT_X_WIDTH:1];
      y1.im <= dif_im[`FFT_X_WIDTH:1];
      {y_out0, y_out1, y_last, y_bank} <= tag2;
   end

endmodule

`default_nettype wire

// ==== rtl/fft_ctrl.sv ====
// Frame sequencer of the FFT.
// Runs each stage as 8 issue cycles plus a drain, then hands off to the output.
`timescale 1ns/1ps
`default_nettype none
`include "fft_cfg.svh"

module fft_ctrl (
   input  logic clk,
   input  logic rst_n,
   input  logic in_full,
   input  logic stage_done,
   input  logic drain_done,
   input  logic first_stage,
   input  logic last_stage,
   input  logic out_busy,
   output logic start_frame,
   output logic step,
   output logic issue,
   output logic start_drain,
   output logic in_release,
   output logic out_load
);

   fft_pkg::ctrl_state_t state;
   // Stage flags captured at the last issue, since the counter moves on.
   logic drain_first;
   logic drain_last;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state       <= fft_pkg::IDLE;
         drain_first <= 1'b0;
         drain_last  <= 1'b0;
      end
      else
      begin
         case (state)
            fft_pkg::IDLE:
               if (in_full)
                  state <= fft_pkg::STAGE;
            fft_pkg::STAGE:
               if (stage_done)
               begin
                  state       <= fft_pkg::DRAIN;
                  drain_first <= first_stage;
                  drain_last  <= last_stage;
               end
            fft_pkg::DRAIN:
               if (drain_done)
               begin
                  if (drain_last)
                     state <= fft_pkg::IDLE;
                  // Last stage writes the output buffer, so it must be idle.
                  else if (last_stage && out_busy)
                     state <= fft_pkg::WAIT_OUT;
                  else
                     state <= fft_pkg::STAGE;
               end
            fft_pkg::WAIT_OUT:
               if (!out_busy)
                  state <= fft_pkg::STAGE;
            default:
               state <= fft_pkg::IDLE;
         endcase
      end
   end

   assign start_frame = (state == fft_pkg::IDLE) && in_full;
   // One butterfly per cycle throughout a stage.
   assign issue       = (state == fft_pkg::STAGE);
   assign step        = issue;
   assign start_drain = issue && stage_done;
   assign in_release  = (state == fft_pkg::DRAIN) && drain_done && drain_first;
   assign out_load    = (state == fft_pkg::DRAIN) && drain_done && drain_last;

endmodule

`default_nettype wire

// ==== rtl/fft_dit_top.sv ====
// Top level of the 16-point radix-2 DIT FFT, output scaled down by N.
// Takes samples on in_nd and streams 16 bins with out_nd.
`timescale 1ns/1ps
`default_nettype none
`include "fft_cfg.svh"

module fft_dit_top (
   input  logic             clk,
   input  logic             rst_n,
   input  fft_pkg::sample_t in_x,
   input  logic             in_nd,
   output fft_pkg::sample_t out_x,
   output logic             out_nd,
   output logic             overflow
);

   fft_pkg::addr_t    in0_addr, in1_addr, out0_addr, out1_addr;
   fft_pkg::tf_addr_t tf_addr;
   fft_pkg::sample_t  ib_rd0, ib_rd1, wr_rd0, wr_rd1, bf_a, bf_b, bf_w, y0, y1;
   fft_pkg::addr_t    y_out0, y_out1;
   logic in_full, in_release, start_frame, step, issue, start_drain, out_load;
   logic first_stage, last_stage, stage_done, drain_done, read_bank, out_busy;
   logic y_valid, y_last, y_bank;

   // Stage 0 reads the input buffer, later stages the work RAM.
   assign bf_a = first_stage ? ib_rd0 : wr_rd0;
   assign bf_b = first_stage ? ib_rd1 : wr_rd1;
   assign bf_w = fft_pkg::TWIDDLE[tf_addr];

   fft_input_buffer u_in_buf (
      .clk, .rst_n, .in_x, .in_nd, .in_release,
      .rd_addr0 (in0_addr), .rd_addr1 (in1_addr),
      .in_full, .overflow, .rd_data0 (ib_rd0), .rd_data1 (ib_rd1)
   );

   fft_stage_counter u_cnt (
      .clk, .rst_n, .start_frame, .step, .start_drain,
      .in0_addr, .in1_addr, .out0_addr, .out1_addr, .tf_addr,
      .first_stage, .last_stage, .stage_done, .drain_done, .read_bank
   );

   fft_ctrl u_ctrl (
      .clk, .rst_n, .in_full, .stage_done, .drain_done, .first_stage,
      .last_stage, .out_busy, .start_frame, .step, .issue, .start_drain,
      .in_release, .out_load
   );

   // Results go to the bank not being read.
   fft_butterfly u_bf (
      .clk, .rst_n, .issue, .a (bf_a), .b (bf_b), .w (bf_w),
      .tag_out0 (out0_addr), .tag_out1 (out1_addr), .tag_last (last_stage),
      .tag_bank (~read_bank), .y_valid, .y0, .y1, .y_out0, .y_out1, .y_last, .y_bank
   );

   fft_work_ram u_work (
      .clk, .wr_en (y_valid && !y_last), .wr_bank (y_bank),
      .wr_addr0 (y_out0), .wr_addr1 (y_out1), .wr_data0 (y0), .wr_data1 (y1),
      .rd_bank (read_bank), .rd_addr0 (in0_addr), .rd_addr1 (in1_addr),
      .rd_data0 (wr_rd0), .rd_data1 (wr_rd1)
   );

   fft_output_buffer u_out (
      .clk, .rst_n, .wr_en (y_valid && y_last), .wr_addr0 (y_out0), .wr_addr1 (y_out1),
      .wr_data0 (y0), .wr_data1 (y1), .out_load, .out_busy, .out_x, .out_nd
   );

endmodule

`default_nettype wire

// ==== rtl/fft_input_buffer.sv ====
// Input frame buffer, filled one sample per in_nd strobe.
// Holds the frame for the first FFT stage until in_release frees it.
`timescale 1ns/1ps
`default_nettype none
`include "fft_cfg.svh"

module fft_input_buffer (
   input  logic             clk,
   input  logic             rst_n,
   input  fft_pkg::sample_t in_x,
   input  logic             in_nd,
   input  logic             in_release,
   input  fft_pkg::addr_t   rd_addr0,
   input  fft_pkg::addr_t   rd_addr1,
   output logic             in_full,
   output logic             overflow,
   output fft_pkg::sample_t rd_data0,
   output fft_pkg::sample_t rd_data1
);

   fft_pkg::sample_t mem [`FFT_N];
   fft_pkg::addr_t   wr_ptr;
   logic             accept;

   // Samples are stored only while the frame is still filling.
   assign accept = in_nd && !in_full;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr   <= '0;
         in_full  <= 1'b0;
         overflow <= 1'b0;
      end
      else
      begin
         if (accept)
            wr_ptr <= wr_ptr + 1'b1;
         // Full once the pointer wraps, free again after stage 0.
         if (accept && (&wr_ptr))
            in_full <= 1'b1;
         else if (in_release)
            in_full <= 1'b0;
         // Sticky until reset.
         if (in_nd && in_full)
            overflow <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         mem[wr_ptr] <= in_x;
   end

   // Two reads for the first stage butterflies.
   assign rd_data0 = mem[rd_addr0];
   assign rd_data1 = mem[rd_addr1];

endmodule

`default_nettype wire

// ==== rtl/fft_output_buffer.sv ====
// Output frame buffer of the FFT.
// Collects last-stage results and streams bins 0 to 15 on consecutive cycles.
`timescale 1ns/1ps
`default_nettype none
`include "fft_cfg.svh"

module fft_output_buffer (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             wr_en,
   input  fft_pkg::addr_t   wr_addr0,
   input  fft_pkg::addr_t   wr_addr1,
   input  fft_pkg::sample_t wr_data0,
   input  fft_pkg::sample_t wr_data1,
   input  logic             out_load,
   output logic             out_busy,
   output fft_pkg::sample_t out_x,
   output logic             out_nd
);

   fft_pkg::sample_t mem [`FFT_N];
   fft_pkg::addr_t   rd_ptr;
   logic             streaming;

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr0] <= wr_data0;
         mem[wr_addr1] <= wr_data1;
      end
   end

   // Stream starts the cycle after out_load and runs one whole frame.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         streaming <= 1'b0;
         rd_ptr    <= '0;
      end
      else if (out_load)
      begin
         streaming <= 1'b1;
         rd_ptr    <= '0;
      end
      else if (streaming)
      begin
         rd_ptr <= rd_ptr + 1'b1;
         if (&rd_ptr)
            streaming <= 1'b0;
      end
   end

   assign out_x    = mem[rd_ptr];
   assign out_nd   = streaming;
   // Busy guards the buffer against the next last stage.
   assign out_busy = streaming;

endmodule

`default_nettype wire

// ==== rtl/fft_pkg.sv ====
// Shared types and the twiddle table of the 16-point DIT FFT.
// RTL and testbench refer to these items as fft_pkg::name.
`default_nettype none
`include "fft_cfg.svh"

package fft_pkg;

   // Complex sample with the real part in the low half.
   typedef struct packed {
      logic signed [`FFT_X_WIDTH-1:0] im;
      logic signed [`FFT_X_WIDTH-1:0] re;
   } sample_t;

   // Sample index within a frame.
   typedef logic [`FFT_NLOG2-1:0] addr_t;

   // Twiddle index, one bit narrower than a sample index.
   typedef logic [`FFT_NLOG2-2:0] tf_addr_t;

   // Frame sequencer states.
   typedef enum logic [1:0] {
      IDLE,
      STAGE,
      DRAIN,
      WAIT_OUT
   } ctrl_state_t;

   // Entry k is cos(2*pi*k/16) and -sin(2*pi*k/16), scaled by 1024.
   localparam sample_t TWIDDLE [8] = '{
      '{re:  1024, im:     0},
      '{re:   946, im:  -392},
      '{re:   724, im:  -724},
      '{re:   392, im:  -946},
      '{re:     0, im: -1024},
      '{re:  -392, im:  -946},
      '{re:  -724, im:  -724},
      '{re:  -946, im:  -392}
   };

endpackage

`default_nettype wire

// ==== rtl/fft_stage_counter.sv ====
// Butterfly address generator and drain timer of the FFT.
// Steps once per issued butterfly and derives read, write and twiddle addresses.
`timescale 1ns/1ps
`default_nettype none
`include "fft_cfg.svh"

module fft_stage_counter (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              start_frame,
   input  logic              step,
   input  logic              start_drain,
   output fft_pkg::addr_t    in0_addr,
   output fft_pkg::addr_t    in1_addr,
   output fft_pkg::addr_t    out0_addr,
   output fft_pkg::addr_t    out1_addr,
   output fft_pkg::tf_addr_t tf_addr,
   output logic              first_stage,
   output logic              last_stage,
   output logic              stage_done,
   output logic              drain_done,
   output logic              read_bank
);

   localparam int DW = $clog2(`FFT_BF_LATENCY + 1);

   // Number of interleaved series in the stage being written.
   fft_pkg::addr_t s;
   // Ones on the bits of out0_addr that pick the series.
   fft_pkg::addr_t series_mask;
   logic [DW-1:0]  drain_cnt;
   logic           drain_active;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         out0_addr   <= '0;
         s           <= fft_pkg::addr_t'(`FFT_N / 2);
         series_mask <= fft_pkg::addr_t'(`FFT_N / 2 - 1);
         read_bank   <= 1'b0;
      end
      else if (start_frame)
      begin
         // A new frame starts again at stage 0.
         out0_addr   <= '0;
         s           <= fft_pkg::addr_t'(`FFT_N / 2);
         series_mask <= fft_pkg::addr_t'(`FFT_N / 2 - 1);
         read_bank   <= 1'b0;
      end
      else if (step)
      begin
         if (stage_done)
         begin
            // Next stage has half as many series.
            out0_addr   <= '0;
            s           <= s >> 1;
            series_mask <= series_mask >> 1;
            read_bank   <= ~read_bank;
         end
         else
            out0_addr <= out0_addr + 1'b1;
      end
   end

   // Series bits stay in place while the k*S bits shift left one place.
   assign in0_addr  = (out0_addr & series_mask) | ((out0_addr & ~series_mask) << 1);
   assign in1_addr  = in0_addr + s;
   // Setting the top bit adds half a frame.
   assign out1_addr = {1'b1, out0_addr[`FFT_NLOG2-2:0]};
   assign tf_addr   = out0_addr[`FFT_NLOG2-2:0] & ~series_mask[`FFT_NLOG2-2:0];

   assign first_stage = (s == fft_pkg::addr_t'(`FFT_N / 2));
   assign last_stage  = (s == fft_pkg::addr_t'(1));
   assign stage_done  = &out1_addr;

   // Counts the butterfly latency after the last issue of a stage.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         drain_active <= 1'b0;
         drain_cnt    <= '0;
      end
      else if (start_drain)
      begin
         drain_active <= 1'b1;
         drain_cnt    <= DW'(`FFT_BF_LATENCY - 1);
      end
      else if (drain_active)
      begin
         if (drain_cnt == '0)
            drain_active <= 1'b0;
         else
            drain_cnt <= drain_cnt - 1'b1;
      end
   end

   assign drain_done = drain_active && (drain_cnt == '0);

endmodule

`default_nettype wire

// ==== rtl/fft_work_ram.sv ====
// X/Y ping-pong working memory between FFT stages.
// One bank takes both butterfly results per cycle while the other is read.
`timescale 1ns/1ps
`default_nettype none
`include "fft_cfg.svh"

module fft_work_ram (
   input  logic             clk,
   input  logic             wr_en,
   input  logic             wr_bank,
   input  fft_pkg::addr_t   wr_addr0,
   input  fft_pkg::addr_t   wr_addr1,
   input  fft_pkg::sample_t wr_data0,
   input  fft_pkg::sample_t wr_data1,
   input  logic             rd_bank,
   input  fft_pkg::addr_t   rd_addr0,
   input  fft_pkg::addr_t   rd_addr1,
   output fft_pkg::sample_t rd_data0,
   output fft_pkg::sample_t rd_data1
);

   // Bank 0 is X, bank 1 is Y.
   fft_pkg::sample_t mem [2][`FFT_N];

   // The two addresses of one butterfly never collide.
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_bank][wr_addr0] <= wr_data0;
         mem[wr_bank][wr_addr1] <= wr_data1;
      end
   end

   // Asynchronous reads for the butterfly inputs.
   assign rd_data0 = mem[rd_bank][rd_addr0];
   assign rd_data1 = mem[rd_bank][rd_addr1];

endmodule

`default_nettype wire
